// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN     = 32;
    localparam int OPC_W    = 5;
    localparam int REG_W    = 5;

    // field positions in the instruction word
    localparam int OPC_MSB  = 31;
    localparam int RD_LSB   = 22;
    localparam int RS1_LSB  = 17;
    localparam int RS2_LSB  = 12;
    localparam int IMM_BITS = 12;  // immediate sits in bits IMM_BITS-1 down to 0

    typedef enum logic [OPC_W-1:0] {
        op_add    = 5'h00,
        op_sub    = 5'h01,
        op_and    = 5'h02,
        op_or     = 5'h03,
        op_xor    = 5'h04,
        op_addi   = 5'h05,
        op_load   = 5'h06,
        op_store  = 5'h07,
        op_branch = 5'h08,
        op_nop    = 5'h1f  // bubble
    } opcode_e;

    typedef struct packed {
        opcode_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  imm;      // sign-extended, zero when unused
        logic             has_imm;
    } decoded_instr_t;

endpackage

`default_nettype wire

// ==== design/dispatch_cfg_pkg.sv ====
`default_nettype none

package dispatch_cfg_pkg;

    localparam int IQ_DEPTH   = 16;
    localparam int IQ_PTR_W   = 4;
    localparam int IQ_SKID    = 1;  // room left for the word sitting in decode
    localparam int ROB_CNT_W  = 6;
    localparam int CFG_DATA_W = 8;

    localparam logic [ROB_CNT_W-1:0] ROB_LIMIT_RESET = 6'd32;

    typedef enum logic {
        cfg_ctrl      = 1'b0,
        cfg_rob_limit = 1'b1
    } cfg_addr_e;

    typedef struct packed {
        logic                 issue_en;
        logic [ROB_CNT_W-1:0] rob_limit;
    } dispatch_cfg_t;

endpackage

`default_nettype wire

// ==== design/instr_decode.sv ====
`default_nettype none

module instr_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic [isa_pkg::XLEN-1:0]     instr_word,
    output logic                         dec_valid,
    output isa_pkg::decoded_instr_t      dec_instr
);

    isa_pkg::opcode_e        opc;
    logic                    legal;
    logic                    takes_imm;
    isa_pkg::decoded_instr_t next_instr;

    assign opc = isa_pkg::opcode_e'(instr_word[isa_pkg::OPC_MSB -: isa_pkg::OPC_W]);

    // classify the opcode
    always_comb begin
        legal     = 1'b1;
        takes_imm = 1'b0;
        case (opc)
            isa_pkg::op_add,
            isa_pkg::op_sub,
            isa_pkg::op_and,
            isa_pkg::op_or,
            isa_pkg::op_xor: begin
                takes_imm = 1'b0;
            end
            isa_pkg::op_addi,
            isa_pkg::op_load,
            isa_pkg::op_store,
            isa_pkg::op_branch: begin
                takes_imm = 1'b1;
            end
            default: begin
                legal = 1'b0;  // nop and unknown encodings are dropped
            end
        endcase
    end

    always_comb begin
        next_instr.op      = opc;
        next_instr.rd      = instr_word[isa_pkg::RD_LSB +: isa_pkg::REG_W];
        next_instr.rs1     = instr_word[isa_pkg::RS1_LSB +: isa_pkg::REG_W];
        next_instr.rs2     = instr_word[isa_pkg::RS2_LSB +: isa_pkg::REG_W];
        next_instr.has_imm = takes_imm;
        if (takes_imm) begin
            next_instr.imm = {{(isa_pkg::XLEN - isa_pkg::IMM_BITS){instr_word[isa_pkg::IMM_BITS-1]}},
                              instr_word[isa_pkg::IMM_BITS-1:0]};
        end else begin
            next_instr.imm = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && legal) begin
            dec_instr <= next_instr;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_queue.sv ====
`default_nettype none

module issue_queue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dec_valid,
    input  isa_pkg::decoded_instr_t         dec_instr,
    input  dispatch_cfg_pkg::dispatch_cfg_t cfg,
    input  logic                            rob_full,
    output logic                            iq_full,
    output logic                            issue_take,
    output logic                            issued,
    output isa_pkg::decoded_instr_t         issue_instr
);

    isa_pkg::decoded_instr_t mem [dispatch_cfg_pkg::IQ_DEPTH];

    logic [dispatch_cfg_pkg::IQ_PTR_W-1:0] head;
    logic [dispatch_cfg_pkg::IQ_PTR_W-1:0] tail;
    logic [dispatch_cfg_pkg::IQ_PTR_W:0]   count;  // one extra bit so all 16 slots count
    logic                                  empty;

    assign empty      = (count == '0);
    assign issue_take = !empty && cfg.issue_en && !rob_full;
    assign iq_full    = (count >= (dispatch_cfg_pkg::IQ_DEPTH - dispatch_cfg_pkg::IQ_SKID));

    // storage
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            mem[tail] <= dec_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_take) begin
            issue_instr <= mem[head];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            issued <= 1'b0;
        end else begin
            issued <= issue_take;
            if (dec_valid) begin
                tail <= tail + 1'b1;  // wraps at 16
            end
            if (issue_take) begin
                head <= head + 1'b1;
            end
            case ({dec_valid, issue_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // upstream honours iq_full and the skid slot covers the word in decode
    assert_no_overflow: assert property (
        @(posedge clk) disable iff (!rst)
        dec_valid |-> (count != dispatch_cfg_pkg::IQ_DEPTH)
    ) else $error("issue_queue: write while holding %0d entries", dispatch_cfg_pkg::IQ_DEPTH);

    // pointer distance and occupancy move together
    assert_ptrs_match_count: assert property (
        @(posedge clk) disable iff (!rst)
        (tail - head) == count[dispatch_cfg_pkg::IQ_PTR_W-1:0]
    ) else $error("issue_queue: head %0d tail %0d disagree with count %0d", head, tail, count);

endmodule

`default_nettype wire

// ==== design/rob_tracker.sv ====
`default_nettype none

module rob_tracker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            issue_take,
    input  logic                            retire,
    input  dispatch_cfg_pkg::dispatch_cfg_t cfg,
    output logic                            rob_full
);

    logic [dispatch_cfg_pkg::ROB_CNT_W-1:0] count;
    logic                                   inc;
    logic                                   dec;

    assign inc      = issue_take;
    assign dec      = retire && (count != '0);  // stray retire at zero is ignored
    assign rob_full = (count >= cfg.rob_limit);  // a lowered limit just stalls issue

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else begin
            case ({inc, dec})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // take and retire cancel
            endcase
        end
    end

    // the queue must only take while there is room below the limit
    assert_take_below_limit: assert property (
        @(posedge clk) disable iff (!rst)
        issue_take |-> (count < cfg.rob_limit)
    ) else $error("rob_tracker: take at count %0d, limit %0d", count, cfg.rob_limit);

    assert_no_retire_at_zero: assert property (
        @(posedge clk) disable iff (!rst)
        retire |-> (count != '0)
    ) else $error("rob_tracker: retire with empty reorder buffer");

endmodule

`default_nettype wire

// ==== design/dispatch_regs.sv ====
`default_nettype none

module dispatch_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cfg_we,
    input  dispatch_cfg_pkg::cfg_addr_e            cfg_addr,
    input  logic [dispatch_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output dispatch_cfg_pkg::dispatch_cfg_t        cfg
);

    logic [dispatch_cfg_pkg::ROB_CNT_W-1:0] new_limit;

    assign new_limit = cfg_wdata[dispatch_cfg_pkg::ROB_CNT_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            cfg.issue_en  <= 1'b1;
            cfg.rob_limit <= dispatch_cfg_pkg::ROB_LIMIT_RESET;
        end else if (cfg_we) begin
            case (cfg_addr)
                dispatch_cfg_pkg::cfg_ctrl: begin
                    cfg.issue_en <= cfg_wdata[0];
                end
                dispatch_cfg_pkg::cfg_rob_limit: begin
                    // a zero limit would deadlock issue, keep the old one
                    if (new_limit != '0) begin
                        cfg.rob_limit <= new_limit;
                    end
                end
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/dispatch_top.sv ====
`default_nettype none

module dispatch_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    instr_valid,
    input  logic [isa_pkg::XLEN-1:0]                instr_word,
    input  logic                                    retire,
    input  logic                                    cfg_we,
    input  dispatch_cfg_pkg::cfg_addr_e             cfg_addr,
    input  logic [dispatch_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic                                    iq_full,
    output logic                                    issued,
    output isa_pkg::decoded_instr_t                 issue_instr
);

    logic                            dec_valid;
    isa_pkg::decoded_instr_t         dec_instr;
    logic                            issue_take;
    logic                            rob_full;
    dispatch_cfg_pkg::dispatch_cfg_t cfg;

    instr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr)
    );

    issue_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .cfg         (cfg),
        .rob_full    (rob_full),
        .iq_full     (iq_full),
        .issue_take  (issue_take),
        .issued      (issued),
        .issue_instr (issue_instr)
    );

    rob_tracker u_rob (
        .clk        (clk),
        .rst        (rst),
        .issue_take (issue_take),
        .retire     (retire),
        .cfg        (cfg),
        .rob_full   (rob_full)
    );

    dispatch_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

endmodule

`default_nettype wire

// ==== test/tb_dispatch.sv ====
`default_nettype none

module tb_dispatch;

    logic                                    clk;
    logic                                    rst;
    logic                                    instr_valid;
    logic [31:0]                             instr_word;
    logic                                    retire;
    logic                                    cfg_we;
    dispatch_cfg_pkg::cfg_addr_e             cfg_addr;
    logic [dispatch_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata;
    logic                                    iq_full;
    logic                                    issued;
    isa_pkg::decoded_instr_t                 issue_instr;

    logic [63:0]             pat [0:191];  // three words per command
    isa_pkg::decoded_instr_t sb [$];       // sent but not yet issued
    int                      occ;          // shadow rob occupancy
    int                      lim;
    int                      mismatches;
    int                      failures;
    int                      cycles;
    int                      cycle_limit;

    dispatch_top dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .retire      (retire),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .iq_full     (iq_full),
        .issued      (issued),
        .issue_instr (issue_instr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_issue();
        isa_pkg::decoded_instr_t exp_i;
        if (sb.size() == 0) begin
            $display("ERROR at %0t: instruction issued with nothing outstanding", $time);
            failures++;
        end else begin
            exp_i = sb.pop_front();
            if (issue_instr !== exp_i) begin
                $display("MISMATCH at %0t: issue_instr got %h expected %h",
                         $time, issue_instr, exp_i);
                mismatches++;
            end
        end
        occ++;
        if (occ > lim) begin
            $display("ERROR at %0t: reorder buffer holds %0d over limit %0d", $time, occ, lim);
            failures++;
        end
    endtask

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (rst && retire) begin
            occ = occ - 1;
        end
        if (rst && issued) begin
            check_issue();
        end
    end

    task automatic run_idle(input int n, input logic [63:0] expv);
        repeat (n) @(posedge clk);
        #1;
        if (occ != int'(expv[7:0])) begin
            $display("MISMATCH at %0t: rob_occupancy got %0d expected %0d",
                     $time, occ, expv[7:0]);
            mismatches++;
        end
        if (iq_full !== expv[8]) begin
            $display("MISMATCH at %0t: iq_full got %b expected %b", $time, iq_full, expv[8]);
            mismatches++;
        end
        if (sb.size() != int'(expv[23:16])) begin
            $display("MISMATCH at %0t: iq_pending got %0d expected %0d",
                     $time, sb.size(), expv[23:16]);
            mismatches++;
        end
    endtask

    task automatic push_instr(input logic [31:0] word, input logic [63:0] expv);
        while (iq_full) begin
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        instr_word  = word;
        if (!expv[63]) begin  // bit 63 marks a dropped word
            sb.push_back(isa_pkg::decoded_instr_t'(expv[$bits(isa_pkg::decoded_instr_t)-1:0]));
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic pulse_retire(input int n);
        repeat (n) begin
            retire = 1'b1;
            @(posedge clk);
            #1;
        end
        retire = 1'b0;
    endtask

    task automatic write_cfg(input logic [63:0] arg);
        cfg_we    = 1'b1;
        cfg_addr  = dispatch_cfg_pkg::cfg_addr_e'(arg[8]);
        cfg_wdata = arg[7:0];
        if (arg[8] && arg[5:0] != 6'd0) begin
            lim = int'(arg[5:0]);  // zero limit is refused
        end
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    initial begin
        int          n_cmds;
        logic [63:0] cmd;
        logic [63:0] arg;
        logic [63:0] expv;
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr_word  = '0;
        retire      = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = dispatch_cfg_pkg::cfg_ctrl;
        cfg_wdata   = '0;
        occ         = 0;
        lim         = int'(dispatch_cfg_pkg::ROB_LIMIT_RESET);
        mismatches  = 0;
        failures    = 0;
        cycles      = 0;
        for (int i = 0; i < $size(pat); i++) begin
            pat[i] = '1;  // end marker
        end
        $readmemh("test/dispatch_patterns.mem", pat);
        n_cmds = 0;
        while (3 * n_cmds < $size(pat) && pat[3 * n_cmds] !== '1) begin
            n_cmds++;
        end
        cycle_limit = n_cmds * 20 + 200;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;
        if (iq_full !== 1'b0 || issued !== 1'b0) begin
            $display("ERROR at %0t: iq_full or issued not low after reset", $time);
            failures++;
        end

        for (int i = 0; i < n_cmds; i++) begin
            cmd  = pat[3 * i];
            arg  = pat[3 * i + 1];
            expv = pat[3 * i + 2];
            case (cmd)
                64'd0: run_idle(int'(arg), expv);
                64'd1: push_instr(arg[31:0], expv);
                64'd2: pulse_retire(int'(arg));
                64'd3: write_cfg(arg);
                default: begin
                    $display("ERROR: pattern line %0d has unknown command %0h", i, cmd);
                    failures++;
                end
            endcase
        end

        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/isa_pkg.sv
design/dispatch_cfg_pkg.sv
design/instr_decode.sv
design/issue_queue.sv
design/rob_tracker.sv
design/dispatch_regs.sv
design/dispatch_top.sv
test/tb_dispatch.sv

// ==== Bender.yml ====
package:
  name: dispatch_path

sources:
  - design/isa_pkg.sv
  - design/dispatch_cfg_pkg.sv
  - design/instr_decode.sv
  - design/issue_queue.sv
  - design/rob_tracker.sv
  - design/dispatch_regs.sv
  - design/dispatch_top.sv
  - target: test
    files:
      - test/tb_dispatch.sv

// ==== test/dispatch_patterns.mem ====
// columns: command, argument, expected (all hex)
// 0 idle/{pending,iq_full,occ}  1 word/struct, 8000.. dropped  2 retires  3 {addr,data}
3 00000104 0                    // rob limit 4
3 00000000 0                    // issue disabled
1 00443abc 886_00000000
1 090a6000 1214c_00000000
1 11d09000 23a12_00000000
1 1a96c000 352d8_00000000
1 27fdd000 4ffba_00000000
1 f8000000 80000000_00000000    // nop
1 28400005 50800_0000000b
1 28820fff 51041_ffffffff
1 30c80800 61901_fffff001
1 380a67ff 7014c_00000fff
1 400e8123 801d0_00000247
1 60443abc 80000000_00000000    // unknown opcode
1 40022ffe 80045_fffffffd
1 00c63000 18c6_00000000
1 0ffff000 1fffe_00000000
1 32120010 64240_00000021
1 3814b900 70297_fffff201
1 20443fff 40886_00000000
0 6        100100               // sixteen held, skid slot used
3 00000001 0
1 194c7000 3298e_00000000       // waits on iq_full
0 a        0d0004
2 1        0
0 4        0c0004
3 00000100 0                    // zero limit
2 2        0
0 4        0a0004
3 00000110 0                    // rob limit 16
0 10       00000e
2 e        0
0 2        000000
